// File: dv/kbd_ref.svh
// expected-value model of the keyboard interface included inside the testbench module
`ifndef KBD_REF_SVH
`define KBD_REF_SVH

// set 1 byte for each set 2 code 0x00..0x7f with code 0 leftmost and 16 codes per line
localparam logic [0:1023] set1_map = {
	128'h00_43_41_3f_3d_3b_3c_58_64_44_42_40_3e_0f_29_59,  // byte 0 unused
	128'h65_38_2a_70_1d_10_02_5a_66_71_2c_1f_1e_11_03_5b,
	128'h67_2e_2d_20_12_05_04_5c_68_39_2f_21_14_13_06_5d,
	128'h69_31_30_23_22_15_07_5e_6a_72_32_24_16_08_09_5f,
	128'h6b_33_25_17_18_0b_0a_60_6c_34_35_26_27_19_0c_61,
	128'h6d_73_28_74_1a_0d_62_6e_3a_36_1c_1b_75_2b_63_76,
	128'h55_56_77_78_79_7a_0e_7b_7c_4f_7d_4b_47_7e_7f_6f,
	128'h52_53_50_4c_4d_48_01_45_57_4e_51_4a_37_49_46_54
};

// set 2 to set 1 as the host should see it
function automatic logic [7:0] set1_of(input logic [7:0] code);
	if (code == 8'h00)
		return `KBD_UNKNOWN;
	if (code == 8'h83)
		return 8'h41;  // F7
	if (code == 8'h84)
		return 8'h54;
	if (code[7])
		return code;   // upper codes pass through
	return set1_map[int'(code[6:0]) * 8 +: 8];
endfunction

// byte expected on pa where break bytes carry bit 7
function automatic logic [7:0] expected_byte(input logic [7:0] code, input logic brk);
	logic [7:0] b;
	b = set1_of(code);
	if (brk)
		b[7] = 1'b1;
	return b;
endfunction

`endif

// File: dv/kbd_tb.sv
// testbench for kbd_if_top that sends PS/2 frames, plays the host on pb6/pb7 and checks pa and irq1
`include "kbd_cfg.svh"

module kbd_tb;

	logic                clk;
	logic                rst_n;
	logic                ps2_clk;
	logic                ps2_data;
	logic                pb6;
	logic                pb7;
	kbd_pkg::scan_code_t pa;
	logic                irq1;

	logic [31:0] lfsr_state;
	int          errors;
	int          tests;
	int          failed;

	`include "kbd_ref.svh"

	kbd_if_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_code(output logic [7:0] code);
		code = 8'h00;
		while (code == 8'h00) begin  // 0x00 is sent on its own
			for (int i = 0; i < 7; i++) begin
				lfsr_state = lfsr_step(lfsr_state);
				code = {code[6:0], lfsr_state[0]};
			end
		end
	endtask

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
			errors++;
		end
	endtask

	// ps2_clk half period of 10 clk cycles with data changing mid high phase
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [`KBD_FRAME_BITS-1:0] bits;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < `KBD_FRAME_BITS; i++) begin
			repeat (5) @(posedge clk);
			ps2_data <= bits[i];
			repeat (5) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (10) @(posedge clk);
			ps2_clk <= 1'b1;
		end
		ps2_data <= 1'b1;
		repeat (10) @(posedge clk);
	endtask

	task automatic watch_irq(input int limit, output logic seen);
		int n;
		n = 0;
		while (!irq1 && n < limit) begin
			@(posedge clk);
			n++;
		end
		seen = irq1;
	endtask

	task automatic require_irq(input string what);
		logic seen;
		watch_irq(100, seen);
		if (!seen) begin
			$display("timeout: irq1 never rose after %s", what);
			errors++;
		end
	endtask

	// pb7 pulse during which pa must read zero
	task automatic ack_irq();
		int n;
		n = 0;
		pb7 <= 1'b1;
		@(posedge clk);
		while (irq1 && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (irq1) begin
			$display("timeout: irq1 stayed high with pb7 asserted");
			errors++;
		end
		check("pa", pa, 8'h00);
		pb7 <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic key_test(input logic [7:0] code, input int prefixes);
		logic seen;
		for (int i = 0; i < prefixes; i++) begin
			send_frame(`KBD_BREAK_PREFIX, 1'b0);
			watch_irq(100, seen);
			check("irq1", {7'd0, seen}, 8'h00);  // prefix alone is silent
		end
		send_frame(code, 1'b0);
		require_irq("a key frame");
		repeat (30) @(posedge clk);
		check("irq1", {7'd0, irq1}, 8'h01);
		check("pa", pa, expected_byte(code, prefixes > 0));
		ack_irq();
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: FAIL with %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		logic [7:0] code;
		logic [7:0] other;
		logic       seen;
		int         mark;
		errors     = 0;
		tests      = 0;
		failed     = 0;
		lfsr_state = 32'd68911;
		rst_n    <= 1'b0;
		ps2_clk  <= 1'b1;
		ps2_data <= 1'b1;
		pb6      <= 1'b1;
		pb7      <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		mark = errors;
		check("pa", pa, 8'h00);
		check("irq1", {7'd0, irq1}, 8'h00);
		watch_irq(50, seen);
		check("irq1", {7'd0, seen}, 8'h00);
		end_test("reset", mark);

		mark = errors;
		for (int k = 0; k < 20; k++) begin
			draw_code(code);
			key_test(code, 0);
		end
		key_test(8'h00, 0);
		key_test(8'h83, 0);
		key_test(8'h84, 0);
		end_test("make codes", mark);

		mark = errors;
		draw_code(code);
		key_test(code, 1);
		draw_code(code);
		key_test(code, 2);  // doubled prefix
		end_test("break codes", mark);

		mark = errors;
		draw_code(code);
		send_frame(code, 1'b1);
		watch_irq(200, seen);
		check("irq1", {7'd0, seen}, 8'h00);
		draw_code(code);
		key_test(code, 0);
		end_test("parity", mark);

		mark = errors;
		draw_code(code);
		send_frame(code, 1'b0);
		require_irq("the first frame");
		draw_code(other);
		send_frame(other, 1'b0);  // lands in hold and is dropped
		check("irq1", {7'd0, irq1}, 8'h01);
		check("pa", pa, expected_byte(code, 1'b0));
		ack_irq();
		watch_irq(200, seen);
		check("irq1", {7'd0, seen}, 8'h00);
		draw_code(code);
		key_test(code, 0);
		end_test("back-pressure", mark);

		mark = errors;
		pb6 <= 1'b0;
		repeat (20) @(posedge clk);
		pb6 <= 1'b1;
		require_irq("the pb6 release");
		check("pa", pa, `KBD_SELF_TEST);
		ack_irq();
		end_test("self-test", mark);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+rtl
+incdir+dv
rtl/kbd_pkg.sv
rtl/ps2_rx.sv
rtl/scan_xlat.sv
rtl/pc_port.sv
rtl/kbd_if_top.sv
dv/kbd_tb.sv

// File: rtl/kbd_cfg.svh
// frame, synchronizer and special byte constants shared by the RTL and the testbench
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// PS/2 frame of start, 8 data, odd parity and stop bits
`define KBD_FRAME_BITS 11

// flops per line synchronizer
`define KBD_SYNC_STAGES 2

// set 2 break prefix that is folded into the following byte
`define KBD_BREAK_PREFIX 8'hF0

// reply to a host hold of the keyboard clock
`define KBD_SELF_TEST 8'hAA

// set 1 value for the unmapped code 0x00
`define KBD_UNKNOWN 8'hFF

`endif

// File: rtl/kbd_if_top.sv
// keyboard interface top level chaining the PS/2 receiver, the translator and the host port
module kbd_if_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic                pb6,
	input  logic                pb7,
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);

	kbd_pkg::scan_code_t raw_code;   // set 2 byte from the receiver
	logic                raw_valid;
	kbd_pkg::scan_code_t key_code;   // translated byte
	logic                key_valid;

	ps2_rx u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.raw_code  (raw_code),
		.raw_valid (raw_valid)
	);

	scan_xlat u_xlat (
		.clk       (clk),
		.rst_n     (rst_n),
		.raw_code  (raw_code),
		.raw_valid (raw_valid),
		.key_code  (key_code),
		.key_valid (key_valid)
	);

	pc_port u_port (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_code  (key_code),
		.key_valid (key_valid),
		.pb6       (pb6),
		.pb7       (pb7),
		.pa        (pa),
		.irq1      (irq1)
	);

endmodule

// File: rtl/kbd_pkg.sv
// shared keyboard interface types used by every RTL module
package kbd_pkg;

	// one byte from the keyboard or to the host
	typedef logic [7:0] scan_code_t;

	// position within a PS/2 frame from 0 to 10
	typedef logic [3:0] bit_cnt_t;

	// host port states
	typedef enum logic [2:0] {
		idle,       // waiting for a key byte
		brk_wait,   // break prefix seen
		hold,       // byte on pa, irq1 raised
		ack_wait,   // pb7 high, waiting for its release
		clk_hold,   // host holds the keyboard clock
		test_wait   // clock released, self-test pending
	} port_state_e;

endpackage

// File: rtl/pc_port.sv
// host port FSM for break folding, irq1 with pb7 acknowledge and the pb6 self-test
`include "kbd_cfg.svh"

module pc_port (
	input  logic                clk,
	input  logic                rst_n,
	input  kbd_pkg::scan_code_t key_code,
	input  logic                key_valid,
	input  logic                pb6,  // low while host holds keyboard clock
	input  logic                pb7,  // irq acknowledge
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);

	kbd_pkg::port_state_e state;
	kbd_pkg::port_state_e state_next;
	kbd_pkg::scan_code_t  pa_next;
	logic                 is_prefix;

	assign is_prefix = (key_code == `KBD_BREAK_PREFIX);

	always_comb begin
		state_next = state;
		pa_next    = pa;
		if (!pb6 && state != kbd_pkg::test_wait) begin
			state_next = kbd_pkg::clk_hold;  // pa keeps its byte
		end else begin
			case (state)
				kbd_pkg::idle: begin
					if (key_valid) begin
						if (is_prefix) begin
							state_next = kbd_pkg::brk_wait;
						end else begin
							state_next = kbd_pkg::hold;
							pa_next    = key_code;
						end
					end
				end
				kbd_pkg::brk_wait: begin
					// repeated prefix just stays here
					if (key_valid && !is_prefix) begin
						state_next = kbd_pkg::hold;
						pa_next    = {1'b1, key_code[6:0]};  // break code
					end
				end
				kbd_pkg::hold: begin
					if (pb7) begin
						state_next = kbd_pkg::ack_wait;
						pa_next    = '0;
					end
				end
				kbd_pkg::ack_wait: begin
					if (!pb7)
						state_next = kbd_pkg::idle;
				end
				kbd_pkg::clk_hold: begin
					state_next = kbd_pkg::test_wait;  // pb6 is high here
				end
				kbd_pkg::test_wait: begin
					if (!pb7) begin
						state_next = kbd_pkg::hold;
						pa_next    = `KBD_SELF_TEST;
					end
				end
				default: begin
					state_next = kbd_pkg::idle;
					pa_next    = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= kbd_pkg::idle;
			pa    <= '0;
			irq1  <= 1'b0;
		end else begin
			state <= state_next;
			pa    <= pa_next;
			// rises one cycle after pa loads and drops with the exit from hold
			irq1  <= (state == kbd_pkg::hold) && (state_next == kbd_pkg::hold);
		end
	end

	a_irq_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		irq1 |-> state == kbd_pkg::hold);

endmodule

// File: rtl/ps2_rx.sv
// PS/2 receiver that syncs both lines into clk and pulses raw_valid for each good frame
`include "kbd_cfg.svh"

module ps2_rx (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,   // async from keyboard
	input  logic                ps2_data,  // async from keyboard
	output kbd_pkg::scan_code_t raw_code,
	output logic                raw_valid
);

	logic [`KBD_SYNC_STAGES-1:0] clk_sync;
	logic [`KBD_SYNC_STAGES-1:0] data_sync;
	logic                        clk_prev;
	logic                        fall_r;     // registered falling edge of ps2_clk
	logic                        data_r;     // data bit that goes with fall_r
	logic [`KBD_FRAME_BITS-2:0]  frame;      // start, data, parity; stop comes in data_r
	kbd_pkg::bit_cnt_t           bit_cnt;
	logic                        last_bit;
	logic                        frame_ok;

	// both lines idle high so the chains reset to ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
			fall_r    <= 1'b0;
			data_r    <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[`KBD_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[`KBD_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_sync[`KBD_SYNC_STAGES-1];
			fall_r    <= clk_prev & ~clk_sync[`KBD_SYNC_STAGES-1];
			data_r    <= data_sync[`KBD_SYNC_STAGES-1];
		end
	end

	assign last_bit = (bit_cnt == kbd_pkg::bit_cnt_t'(`KBD_FRAME_BITS - 1));

	// start low, odd parity over data and parity bit, stop high
	assign frame_ok = !frame[0] && (^frame[`KBD_FRAME_BITS-2:1]) && data_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			raw_valid <= 1'b0;
		end else begin
			raw_valid <= 1'b0;
			if (fall_r) begin
				if (last_bit) begin
					bit_cnt   <= '0;       // restart whether or not the frame checks
					raw_valid <= frame_ok;
				end else if (bit_cnt == '0 && data_r) begin
					bit_cnt <= '0;         // high line is not a start bit so keep waiting
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// shift register and captured byte
	always_ff @(posedge clk) begin
		if (fall_r && !last_bit)
			frame <= {data_r, frame[`KBD_FRAME_BITS-2:1]};  // lsb first
		if (fall_r && last_bit && frame_ok)
			raw_code <= frame[8:1];
	end

	// a frame takes many clk cycles so two back-to-back pulses mean a broken counter
	a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		raw_valid |=> !raw_valid);

endmodule

// File: rtl/scan_xlat.sv
// scan code set 2 to set 1 translator forming one register stage before the host port
`include "kbd_cfg.svh"

module scan_xlat (
	input  logic                clk,
	input  logic                rst_n,
	input  kbd_pkg::scan_code_t raw_code,
	input  logic                raw_valid,
	output kbd_pkg::scan_code_t key_code,
	output logic                key_valid
);

	// set 1 codes for set 2 codes 0x00..0x7f in rows of eight
	localparam kbd_pkg::scan_code_t set1_tbl [0:127] = '{
		`KBD_UNKNOWN, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,   // 00
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,          // 10
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,          // 20
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,          // 30
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,          // 40
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,          // 50
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,          // 60
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,          // 70
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	kbd_pkg::scan_code_t xlat;

	always_comb begin
		if (!raw_code[7]) begin
			xlat = set1_tbl[raw_code[6:0]];
		end else begin
			case (raw_code)
				8'h83:   xlat = 8'h41;     // F7 sits outside the main block
				8'h84:   xlat = 8'h54;     // alt+sysrq
				default: xlat = raw_code;  // prefixes such as F0 pass through
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			key_valid <= 1'b0;
		else
			key_valid <= raw_valid;
	end

	always_ff @(posedge clk) begin
		if (raw_valid)
			key_code <= xlat;  // holds between bytes
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module kbd_tb -o kbd_sim
./obj_dir/kbd_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
